// ==== vlog.f ====
+incdir+include
hw/afifo_pkg.sv
hw/afifo_push_stage.sv
hw/core_afifo.sv
hw/afifo_pop_stage.sv
hw/afifo_top.sv
test/afifo_assertions.sv
test/tb_afifo.sv

// ==== test/tb_afifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "afifo_consts.svh"

module tb_afifo;

  import afifo_pkg::*;

  localparam int DEPTH      = `AFIFO_DEPTH;
  localparam int NUM_PHASES = 5;
  localparam int IDLE_CYC   = 20;

  localparam int K_RESET     = 0;
  localparam int K_ORDER     = 1;
  localparam int K_OVERFLOW  = 2;
  localparam int K_UNDERFLOW = 3;
  localparam int K_STREAM    = 4;

  typedef struct packed {
    int kind;
    int n_push;
    int n_pop;
    int exp_push_err;
    int exp_pop_err;
  } phase_t;

  // kind, pushes, pops, expected push_err count, expected pop_err count
  phase_t phases [NUM_PHASES] = '{
    '{K_RESET,     0,         0,     0, 0},
    '{K_ORDER,     5,         5,     0, 0},
    '{K_OVERFLOW,  DEPTH + 3, DEPTH, 3, 0},
    '{K_UNDERFLOW, 0,         3,     0, 3},
    '{K_STREAM,    40,        40,    0, 0}
  };

  logic  push_clk;
  logic  pop_clk;
  logic  po_rst;
  logic  push;
  data_t push_data;
  logic  push_err;
  logic  full;
  logic  pop;
  data_t pop_data;
  logic  pop_vld;
  logic  pop_err;
  logic  empty;

  data_t       sb [$];                // Accepted words in push order
  logic [15:0] lfsr_state = 16'd51016;
  int          errors = 0;
  int          phase_errs = 0;
  int          push_err_seen = 0;
  int          pop_err_seen = 0;
  int          phases_passed = 0;
  int          phases_failed = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  afifo_top u_afifo_top (
    .push_clk  (push_clk),
    .pop_clk   (pop_clk),
    .po_rst    (po_rst),
    .push      (push),
    .push_data (push_data),
    .push_err  (push_err),
    .full      (full),
    .pop       (pop),
    .pop_data  (pop_data),
    .pop_vld   (pop_vld),
    .pop_err   (pop_err),
    .empty     (empty)
  );

  initial begin
    push_clk = 1'b0;
    forever #5 push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    forever #7 pop_clk = ~pop_clk;
  end

  function automatic string phase_name(input int kind);
    case (kind)
      K_RESET:     return "reset";
      K_ORDER:     return "ordering";
      K_OVERFLOW:  return "overflow";
      K_UNDERFLOW: return "underflow";
      default:     return "streaming";
    endcase
  endfunction

  // Galois form, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_word(output data_t w);
    w = '0;
    for (int i = 0; i < $bits(data_t); i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[$bits(data_t)-2:0], lfsr_state[0]};   // One step per bit
    end
  endtask

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
    phase_errs++;
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) report_fail($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) report_fail($sformatf("%s is %b expected %b", what, got, exp));
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    if (got !== exp) report_fail($sformatf("%s raised %b expected %b", what, got, exp));
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) report_fail($sformatf("%s is %0d expected %0d", what, got, exp));
  endtask

  // Flags after an idle gap, judged against the scoreboard
  task automatic check_settled_flags();
    @(negedge push_clk);
    check_flag("empty", empty, sb.size() == 0);
    check_flag("full", full, sb.size() >= DEPTH);
    check_flag("pop_vld", pop_vld, 1'b0);
    check_err("push_err", push_err, 1'b0);
    check_err("pop_err", pop_err, 1'b0);
  endtask

  task automatic push_words(input int n, input bit stream);
    data_t w;
    logic  exp_err;
    @(negedge push_clk);
    for (int i = 0; i < n; i++) begin
      while (stream && full) @(negedge push_clk);
      draw_word(w);
      @(posedge push_clk);
      push      <= 1'b1;
      push_data <= w;
      @(posedge push_clk);
      push <= 1'b0;
      @(negedge push_clk);                  // push_err of the sampled push
      exp_err = !stream && (sb.size() >= DEPTH);
      check_err("push_err", push_err, exp_err);
      if (push_err) push_err_seen++;
      if (!exp_err) sb.push_back(w);
    end
  endtask

  task automatic pop_words(input int n, input bit stream);
    logic  exp_vld;
    data_t exp_data;
    @(negedge pop_clk);
    for (int i = 0; i < n; i++) begin
      while (stream && empty) @(negedge pop_clk);
      @(posedge pop_clk);
      pop <= 1'b1;
      @(posedge pop_clk);
      pop <= 1'b0;
      @(negedge pop_clk);                   // Response one cycle after sampling
      exp_vld = (sb.size() != 0);
      check_flag("pop_vld", pop_vld, exp_vld);
      check_err("pop_err", pop_err, !exp_vld);
      if (pop_err) pop_err_seen++;
      if (exp_vld) begin
        exp_data = sb.pop_front();
        check_data("pop_data", pop_data, exp_data);
      end
    end
  endtask

  task automatic run_phase(input phase_t p);
    phase_errs    = 0;
    push_err_seen = 0;
    pop_err_seen  = 0;
    case (p.kind)
      K_RESET: ;  // Flags only
      K_STREAM: begin
        fork
          push_words(p.n_push, 1'b1);
          pop_words(p.n_pop, 1'b1);
        join
      end
      default: begin
        push_words(p.n_push, 1'b0);
        repeat (IDLE_CYC) @(posedge push_clk);
        @(negedge push_clk);
        check_flag("full", full, sb.size() >= DEPTH);
        pop_words(p.n_pop, 1'b0);
      end
    endcase
    repeat (IDLE_CYC) @(posedge push_clk);
    check_settled_flags();
    check_count("push_err count", push_err_seen, p.exp_push_err);
    check_count("pop_err count", pop_err_seen, p.exp_pop_err);
  endtask

  // Watchdog sized from the table
  initial begin
    cycle_limit = 200;
    for (int i = 0; i < NUM_PHASES; i++) begin
      cycle_limit += 4 * (phases[i].n_push + phases[i].n_pop);
    end
    while (cycles < cycle_limit) begin
      @(posedge push_clk);
      cycles++;
    end
    $display("Error: timed out waiting for phase to finish after %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    po_rst    = 1'b1;
    push      = 1'b0;
    push_data = '0;
    pop       = 1'b0;
    repeat (3) @(posedge push_clk);
    po_rst <= 1'b0;
    repeat (10) @(posedge push_clk);   // Pop reset chain and pointers settle
    for (int i = 0; i < NUM_PHASES; i++) begin
      run_phase(phases[i]);
      if (phase_errs == 0) begin
        phases_passed++;
        $display("phase %0d %s: ok", i, phase_name(phases[i].kind));
      end else begin
        phases_failed++;
        $display("phase %0d %s: %0d mismatches", i, phase_name(phases[i].kind), phase_errs);
      end
    end
    $display("phases passed: %0d, phases failed: %0d", phases_passed, phases_failed);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/afifo_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module afifo_assertions (
  input logic             push_clk,
  input logic             pop_clk,
  input logic             po_rst,
  input logic             pop_rst,
  input afifo_pkg::jptr_t wptr_q,
  input afifo_pkg::jptr_t rptr_q,
  input afifo_pkg::jptr_t rptr_in_push,
  input logic             wr_vld,
  input logic             rd
);

  // A Johnson step flips a single bit
  wptr_one_bit: assert property (@(posedge push_clk) disable iff (po_rst)
    $countones(wptr_q ^ $past(wptr_q)) <= 1)
    else $error("write pointer changed more than one bit in a cycle");

  // Pop reset is unknown until the sync chain fills
  rptr_one_bit: assert property (@(posedge pop_clk) disable iff (pop_rst !== 1'b0)
    $countones(rptr_q ^ $past(rptr_q)) <= 1)
    else $error("read pointer changed more than one bit in a cycle");

  // Stored pointers only, the in-flight word is allowed to fill the last slot
  no_write_when_full: assert property (@(posedge push_clk) disable iff (po_rst)
    wr_vld |-> (wptr_q != ~rptr_in_push))
    else $error("write issued into a full memory");

  // Head entry really written, so empty never clears early
  no_read_when_empty: assert property (@(posedge pop_clk) disable iff (pop_rst !== 1'b0)
    rd |-> (rptr_q != wptr_q))
    else $error("read issued on an empty FIFO");

endmodule

bind core_afifo afifo_assertions u_afifo_assertions (
  .push_clk     (push_clk),
  .pop_clk      (pop_clk),
  .po_rst       (po_rst),
  .pop_rst      (pop_rst),
  .wptr_q       (wptr_q),
  .rptr_q       (rptr_q),
  .rptr_in_push (rptr_in_push),
  .wr_vld       (wr_req.vld),
  .rd           (rd)
);

`default_nettype wire

// ==== hw/afifo_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module afifo_top (
  input  logic             push_clk,
  input  logic             pop_clk,
  input  logic             po_rst,
  input  logic             push,
  input  afifo_pkg::data_t push_data,
  output logic             push_err,
  output logic             full,
  input  logic             pop,
  output afifo_pkg::data_t pop_data,
  output logic             pop_vld,
  output logic             pop_err,
  output logic             empty
);

  import afifo_pkg::*;

  wr_req_t wr_req;
  rd_rsp_t rd_rsp;
  data_t   rd_data;
  logic    rd;
  logic    pop_rst;   // Reset as seen in pop_clk

  afifo_push_stage u_push_stage (
    .push_clk  (push_clk),
    .po_rst    (po_rst),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .wr_req    (wr_req),
    .push_err  (push_err)
  );

  core_afifo u_core_afifo (
    .push_clk (push_clk),
    .pop_clk  (pop_clk),
    .po_rst   (po_rst),
    .wr_req   (wr_req),
    .rd       (rd),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .pop_rst  (pop_rst)
  );

  afifo_pop_stage u_pop_stage (
    .pop_clk (pop_clk),
    .pop_rst (pop_rst),
    .pop     (pop),
    .empty   (empty),
    .rd_data (rd_data),
    .rd      (rd),
    .rd_rsp  (rd_rsp),
    .pop_err (pop_err)
  );

  // Response split onto the output pins
  assign pop_vld  = rd_rsp.vld;
  assign pop_data = rd_rsp.data;

endmodule

`default_nettype wire

// ==== hw/afifo_pop_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module afifo_pop_stage (
  input  logic               pop_clk,
  input  logic               pop_rst,
  input  logic               pop,
  input  logic               empty,
  input  afifo_pkg::data_t   rd_data,
  output logic               rd,
  output afifo_pkg::rd_rsp_t rd_rsp,
  output logic               pop_err
);

  logic                      rsp_vld_q;
  logic [$bits(rd_data)-1:0] rsp_data_q;

  // Only read while something is there
  assign rd = pop & ~empty;

  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      rsp_vld_q <= 1'b0;
      pop_err   <= 1'b0;
    end else begin
      rsp_vld_q <= rd;
      pop_err   <= pop & empty;   // Underflow, no data returned
    end
  end

  // Head word captured on the edge that advances the pointer
  always_ff @(posedge pop_clk) begin
    if (rd) begin
      rsp_data_q <= rd_data;
    end
  end

  assign rd_rsp.vld  = rsp_vld_q;
  assign rd_rsp.data = rsp_data_q;

endmodule

`default_nettype wire

// ==== hw/core_afifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "afifo_consts.svh"

module core_afifo (
  input  logic               push_clk,
  input  logic               pop_clk,
  input  logic               po_rst,
  input  afifo_pkg::wr_req_t wr_req,
  input  logic               rd,
  output afifo_pkg::data_t   rd_data,
  output logic               full,
  output logic               empty,
  output logic               pop_rst
);

  import afifo_pkg::*;

  localparam int NSYNC = `AFIFO_SYNC_STAGES;
  localparam int DEPTH = `AFIFO_DEPTH;

  // Storage, written on push_clk only
  data_t mem [DEPTH];

  // Push domain
  jptr_t             wptr_q;
  jptr_t             wptr_nxt;
  idx_t              widx;
  jptr_t [NSYNC-1:0] rptr_sync_q;   // Read pointer seen from push side
  jptr_t             rptr_in_push;

  // Pop domain
  jptr_t             rptr_q;
  idx_t              ridx;
  jptr_t [NSYNC-1:0] wptr_sync_q;   // Write pointer seen from pop side
  jptr_t             wptr_in_pop;
  logic  [NSYNC-1:0] pop_rst_q;

  // Johnson state number modulo depth
  // Lower half counts ones, upper half counts zeros
  function automatic idx_t jptr_idx(input jptr_t p);
    jptr_t m;
    idx_t  n;
    m = p[DEPTH-1] ? ~p : p;
    n = '0;
    for (int i = 0; i < DEPTH; i++) begin
      n = n + idx_t'(m[i]);
    end
    return n;
  endfunction

  // One Johnson step, a single bit flips
  function automatic jptr_t jptr_step(input jptr_t p);
    return {p[DEPTH-2:0], ~p[DEPTH-1]};
  endfunction

  // Reset into the pop domain
  always_ff @(posedge pop_clk) begin
    pop_rst_q <= {pop_rst_q[NSYNC-2:0], po_rst};
  end

  assign pop_rst = pop_rst_q[NSYNC-1];

  // Write side
  assign wptr_nxt = jptr_step(wptr_q);
  assign widx     = jptr_idx(wptr_q);

  always_ff @(posedge push_clk) begin
    if (po_rst) begin
      wptr_q <= '0;
    end else if (wr_req.vld) begin
      wptr_q <= wptr_nxt;
    end
  end

  always_ff @(posedge push_clk) begin
    if (wr_req.vld) begin
      mem[widx] <= wr_req.data;
    end
  end

  // Read pointer into push_clk
  always_ff @(posedge push_clk) begin
    if (po_rst) begin
      rptr_sync_q <= '0;
    end else begin
      rptr_sync_q <= {rptr_sync_q[NSYNC-2:0], rptr_q};
    end
  end

  assign rptr_in_push = rptr_sync_q[NSYNC-1];

  // Inverse pointer means DEPTH entries ahead
  // The in-flight write counts already
  assign full = (wptr_q == ~rptr_in_push) |
                (wr_req.vld & (wptr_nxt == ~rptr_in_push));

  // Read side
  assign ridx    = jptr_idx(rptr_q);
  assign rd_data = mem[ridx];       // Combinational read at head

  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      rptr_q <= '0;
    end else if (rd) begin
      rptr_q <= jptr_step(rptr_q);
    end
  end

  // Write pointer into pop_clk
  always_ff @(posedge pop_clk) begin
    if (pop_rst) begin
      wptr_sync_q <= '0;
    end else begin
      wptr_sync_q <= {wptr_sync_q[NSYNC-2:0], wptr_q};
    end
  end

  assign wptr_in_pop = wptr_sync_q[NSYNC-1];

  assign empty = (rptr_q == wptr_in_pop);

endmodule

`default_nettype wire

// ==== hw/afifo_push_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module afifo_push_stage (
  input  logic              push_clk,
  input  logic              po_rst,
  input  logic              push,
  input  afifo_pkg::data_t  push_data,
  input  logic              full,
  output afifo_pkg::wr_req_t wr_req,
  output logic              push_err
);

  logic             accept;
  logic             wr_vld_q;
  logic [$bits(push_data)-1:0] wr_data_q;

  // A push gets in only while the core has room
  assign accept = push & ~full;

  always_ff @(posedge push_clk) begin
    if (po_rst) begin
      wr_vld_q <= 1'b0;
      push_err <= 1'b0;
    end else begin
      wr_vld_q <= accept;
      // Refused push, word is dropped
      push_err <= push & full;
    end
  end

  // Data register only loads on an accepted push
  always_ff @(posedge push_clk) begin
    if (accept) begin
      wr_data_q <= push_data;
    end
  end

  assign wr_req.vld  = wr_vld_q;
  assign wr_req.data = wr_data_q;

endmodule

`default_nettype wire

// ==== hw/afifo_pkg.sv ====
`default_nettype none

`include "afifo_consts.svh"

package afifo_pkg;

  // One sample as carried end to end
  typedef logic [`AFIFO_WIDTH-1:0] data_t;

  // Johnson-coded pointer, 2*DEPTH states
  typedef logic [`AFIFO_DEPTH-1:0] jptr_t;

  // Memory index decoded from a pointer
  typedef logic [`AFIFO_IDX_BITS-1:0] idx_t;

  // Push stage to core write request
  typedef struct packed {
    logic  vld;
    data_t data;
  } wr_req_t;

  // Pop stage response toward the outputs
  typedef struct packed {
    logic  vld;
    data_t data;
  } rd_rsp_t;

endpackage

`default_nettype wire

// ==== include/afifo_consts.svh ====
`ifndef AFIFO_CONSTS_SVH
`define AFIFO_CONSTS_SVH

// Sample word width
`define AFIFO_WIDTH 32
// Memory entries, also the Johnson pointer width
`define AFIFO_DEPTH 8
// Flops per clock crossing chain
`define AFIFO_SYNC_STAGES 2
// log2 of AFIFO_DEPTH
`define AFIFO_IDX_BITS 3

`endif
